// ==== scan_pkg.sv ====
package scan_pkg;

   // Number of category lanes, default for the top level
   localparam int NUM_LANES = 4;

   // Stream id width and the stream count it gives
   localparam int STREAM_W = 6;
   localparam int NUM_STREAMS = 2 ** STREAM_W;

   // Width of the per-lane packet match counter
   localparam int COUNT_W = 16;

   // Signature length in bytes
   localparam int SIG_LEN = 4;

   // One literal per lane, index 0 is lane 0
   // First character sits in the top byte
   // None of them overlaps itself, so a mismatch restarts from byte 0
   localparam logic [NUM_LANES-1:0][8*SIG_LEN-1:0] SIGNATURES = {
      "XMAS",
      "ROOT",
      "EVIL",
      "GET "
   };

   // Matcher state, counts leading signature bytes seen so far
   typedef enum logic [2:0] {
      MS_IDLE  = 3'd0,
      MS_ONE   = 3'd1,
      MS_TWO   = 3'd2,
      MS_THREE = 3'd3
   } match_state_e;

endpackage

// ==== stream_table.sv ====
module stream_table #(
   parameter int NUM_LANES = scan_pkg::NUM_LANES
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          sop,
   input  logic [scan_pkg::STREAM_W-1:0] stream_id,
   input  logic                          cfg_wr,
   input  logic [scan_pkg::STREAM_W-1:0] cfg_stream,
   input  logic [NUM_LANES-1:0]          cfg_mask,
   output logic                          load_state,
   output logic                          new_stream_id,
   output logic [scan_pkg::STREAM_W-1:0] cur_stream,
   output logic [NUM_LANES-1:0]          lane_enable
);

   // One bit per stream that is set on its first sop
   logic [scan_pkg::NUM_STREAMS-1:0] seen;

   // Category enables per stream as written by the config port
   logic [NUM_LANES-1:0] enable_mem [scan_pkg::NUM_STREAMS];

   // Config writes
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < scan_pkg::NUM_STREAMS; i++)
         begin
            enable_mem[i] <= '0;
         end
      end
      else if (cfg_wr)
      begin
         enable_mem[cfg_stream] <= cfg_mask;
      end
   end

   // Packet start handling
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         seen          <= '0;
         load_state    <= 1'b0;
         new_stream_id <= 1'b0;
         cur_stream    <= '0;
         lane_enable   <= '0;
      end
      else
      begin
         // Single-cycle strobe to the lanes
         load_state <= sop;
         if (sop)
         begin
            // Stream never seen means the lanes start from idle
            new_stream_id     <= ~seen[stream_id];
            seen[stream_id]   <= 1'b1;
            // Held until the next sop for the lanes and the reporter at eop
            cur_stream        <= stream_id;
            lane_enable       <= enable_mem[stream_id];
         end
      end
   end

endmodule

// ==== pattern_dfa.sv ====
module pattern_dfa #(
   parameter int LANE_ID = 0
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic [7:0]             char_in,
   input  logic                   char_in_vld,
   input  scan_pkg::match_state_e state_in,
   input  logic                   state_in_vld,
   output scan_pkg::match_state_e state_out,
   output logic                   accept_out
);

   // This lane's literal, first character in the top byte
   localparam logic [8*scan_pkg::SIG_LEN-1:0] SIG = scan_pkg::SIGNATURES[LANE_ID];
   localparam logic [7:0] FIRST_BYTE = SIG[8*scan_pkg::SIG_LEN-1 -: 8];

   scan_pkg::match_state_e state;
   scan_pkg::match_state_e adv_state;
   logic [7:0]             exp_byte;
   logic                   last_byte;

   // Next expected byte, the state value is the number of bytes matched
   always_comb
   begin
      exp_byte = SIG[8*(scan_pkg::SIG_LEN-1-int'(state)) +: 8];
   end

   // State after a matching byte
   always_comb
   begin
      last_byte = 1'b0;
      case (state)
         scan_pkg::MS_IDLE:  adv_state = scan_pkg::MS_ONE;
         scan_pkg::MS_ONE:   adv_state = scan_pkg::MS_TWO;
         scan_pkg::MS_TWO:   adv_state = scan_pkg::MS_THREE;
         default:
         begin
            // Fourth byte completes the signature
            adv_state = scan_pkg::MS_IDLE;
            last_byte = 1'b1;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state      <= scan_pkg::MS_IDLE;
         accept_out <= 1'b0;
      end
      else
      begin
         accept_out <= 1'b0;
         // Restore from the lane wins over any character
         if (state_in_vld)
            state <= state_in;
         else if (char_in_vld)
         begin
            if (char_in == exp_byte)
            begin
               state      <= adv_state;
               accept_out <= last_byte;
            end
            // No self-overlap, so only the first byte can restart a match
            else if (char_in == FIRST_BYTE)
               state <= scan_pkg::MS_ONE;
            else
               state <= scan_pkg::MS_IDLE;
         end
      end
   end

   assign state_out = state;

endmodule

// ==== category_lane.sv ====
module category_lane #(
   parameter int LANE_ID = 0
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          load_state,
   input  logic                          new_stream_id,
   input  logic [scan_pkg::STREAM_W-1:0] cur_stream,
   input  logic                          enable,
   input  logic [7:0]                    char_in,
   input  logic                          char_in_vld,
   input  logic                          eop,
   output logic                          fired,
   output logic [scan_pkg::COUNT_W-1:0]  count
);

   // Saved matcher state per stream
   scan_pkg::match_state_e state_mem [scan_pkg::NUM_STREAMS];

   scan_pkg::match_state_e state_in;
   scan_pkg::match_state_e state_out;
   logic                   state_in_vld;
   logic                   accept_out;

   // Restore strobe, one cycle behind load_state
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state_in_vld <= 1'b0;
      else
         state_in_vld <= load_state;
   end

   // Unknown stream restarts from idle, else pick up where it stopped
   always_ff @(posedge clk)
   begin
      if (load_state)
         state_in <= new_stream_id ? scan_pkg::MS_IDLE : state_mem[cur_stream];
   end

   // State memory
   // First packet of a stream seeds the entry with idle
   // so a lane enabled later never reads a stale slot
   always_ff @(posedge clk)
   begin
      if (load_state && new_stream_id)
         state_mem[cur_stream] <= scan_pkg::MS_IDLE;
      else if (eop && enable)
         state_mem[cur_stream] <= state_out;
   end

   // Per-packet fired flag and packet counter
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         fired <= 1'b0;
         count <= '0;
      end
      else
      begin
         // Fresh packet
         if (load_state)
            fired <= 1'b0;
         // Any accept inside the packet marks it
         if (accept_out)
            fired <= 1'b1;
         if (eop)
         begin
            if (enable)
               count <= count + {{(scan_pkg::COUNT_W-1){1'b0}}, fired};
            else
               fired <= 1'b0;
         end
      end
   end

   pattern_dfa #(
      .LANE_ID (LANE_ID)
   ) u_dfa (
      .clk          (clk),
      .rst_n        (rst_n),
      .char_in      (char_in),
      .char_in_vld  (char_in_vld),
      .state_in     (state_in),
      .state_in_vld (state_in_vld),
      .state_out    (state_out),
      .accept_out   (accept_out)
   );

endmodule

// ==== match_reporter.sv ====
module match_reporter #(
   parameter int NUM_LANES = scan_pkg::NUM_LANES
) (
   input  logic                                    clk,
   input  logic                                    rst_n,
   input  logic                                    eop,
   input  logic [scan_pkg::STREAM_W-1:0]           cur_stream,
   input  logic [NUM_LANES-1:0]                    lane_enable,
   input  logic [NUM_LANES-1:0]                    lane_fired,
   input  logic [NUM_LANES*scan_pkg::COUNT_W-1:0]  lane_count,
   input  logic [SEL_W-1:0]                        count_sel,
   output logic                                    report_vld,
   output logic [scan_pkg::STREAM_W-1:0]           report_stream,
   output logic [NUM_LANES-1:0]                    report_mask,
   output logic [scan_pkg::COUNT_W-1:0]            count_value
);

   // Lane index width, at least one bit
   localparam int SEL_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

   // End-of-packet report
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         report_vld <= 1'b0;
      else
         report_vld <= eop;
   end

   // Fired flags are still valid at eop, lanes clear them on the same edge
   always_ff @(posedge clk)
   begin
      if (eop)
      begin
         report_stream <= cur_stream;
         report_mask   <= lane_fired & lane_enable;
      end
   end

   // Counter readback, one cycle behind count_sel
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         count_value <= '0;
      else if (int'(count_sel) < NUM_LANES)
         count_value <= lane_count[int'(count_sel)*scan_pkg::COUNT_W +: scan_pkg::COUNT_W];
      else
         // Index past the last lane reads zero
         count_value <= '0;
   end

endmodule

// ==== packet_scanner_top.sv ====
module packet_scanner_top #(
   parameter int NUM_LANES = scan_pkg::NUM_LANES
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          sop,
   input  logic [scan_pkg::STREAM_W-1:0] stream_id,
   input  logic [7:0]                    char_in,
   input  logic                          char_in_vld,
   input  logic                          eop,
   input  logic                          cfg_wr,
   input  logic [scan_pkg::STREAM_W-1:0] cfg_stream,
   input  logic [NUM_LANES-1:0]          cfg_mask,
   input  logic [SEL_W-1:0]              count_sel,
   output logic                          report_vld,
   output logic [scan_pkg::STREAM_W-1:0] report_stream,
   output logic [NUM_LANES-1:0]          report_mask,
   output logic [scan_pkg::COUNT_W-1:0]  count_value
);

   // Lane index width, matches the reporter
   localparam int SEL_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

   // Table to lanes
   logic                          load_state;
   logic                          new_stream_id;
   logic [scan_pkg::STREAM_W-1:0] cur_stream;
   logic [NUM_LANES-1:0]          lane_enable;

   // Lanes to reporter, counters flattened lane 0 first
   logic [NUM_LANES-1:0]                   lane_fired;
   logic [NUM_LANES*scan_pkg::COUNT_W-1:0] lane_count;

   stream_table #(
      .NUM_LANES (NUM_LANES)
   ) u_table (
      .clk           (clk),
      .rst_n         (rst_n),
      .sop           (sop),
      .stream_id     (stream_id),
      .cfg_wr        (cfg_wr),
      .cfg_stream    (cfg_stream),
      .cfg_mask      (cfg_mask),
      .load_state    (load_state),
      .new_stream_id (new_stream_id),
      .cur_stream    (cur_stream),
      .lane_enable   (lane_enable)
   );

   // One lane per category, each with its own signature
   for (genvar i = 0; i < NUM_LANES; i++)
   begin : g_lane
      category_lane #(
         .LANE_ID (i)
      ) u_lane (
         .clk           (clk),
         .rst_n         (rst_n),
         .load_state    (load_state),
         .new_stream_id (new_stream_id),
         .cur_stream    (cur_stream),
         .enable        (lane_enable[i]),
         .char_in       (char_in),
         .char_in_vld   (char_in_vld),
         .eop           (eop),
         .fired         (lane_fired[i]),
         .count         (lane_count[i*scan_pkg::COUNT_W +: scan_pkg::COUNT_W])
      );
   end

   match_reporter #(
      .NUM_LANES (NUM_LANES)
   ) u_reporter (
      .clk           (clk),
      .rst_n         (rst_n),
      .eop           (eop),
      .cur_stream    (cur_stream),
      .lane_enable   (lane_enable),
      .lane_fired    (lane_fired),
      .lane_count    (lane_count),
      .count_sel     (count_sel),
      .report_vld    (report_vld),
      .report_stream (report_stream),
      .report_mask   (report_mask),
      .count_value   (count_value)
   );

endmodule

// ==== packet_scanner_sva.sv ====
module packet_scanner_sva (
   input logic clk,
   input logic rst_n,
   input logic sop,
   input logic eop,
   input logic char_in_vld,
   input logic load_state,
   input logic report_vld
);

   // Report strobe trails eop by exactly one cycle
   eop_gives_report: assert property (@(posedge clk) disable iff (!rst_n) eop |=> report_vld)
      else $error("report_vld missing one cycle after eop");

   report_needs_eop: assert property (@(posedge clk) disable iff (!rst_n)
      report_vld |-> $past(eop))
      else $error("report_vld without eop one cycle before");

   // Table strobe trails sop by exactly one cycle
   sop_gives_load: assert property (@(posedge clk) disable iff (!rst_n) sop |=> load_state)
      else $error("load_state missing one cycle after sop");

   load_needs_sop: assert property (@(posedge clk) disable iff (!rst_n)
      load_state |-> $past(sop))
      else $error("load_state without sop one cycle before");

   // Lanes restore state in these two cycles, characters would be lost
   sop_char_gap: assert property (@(posedge clk) disable iff (!rst_n)
      sop |=> !char_in_vld [*2])
      else $error("char_in_vld within two cycles after sop");

endmodule

bind packet_scanner_top packet_scanner_sva u_sva (
   .clk         (clk),
   .rst_n       (rst_n),
   .sop         (sop),
   .eop         (eop),
   .char_in_vld (char_in_vld),
   .load_state  (load_state),
   .report_vld  (report_vld)
);

// ==== packet_scanner_tb.sv ====
module packet_scanner_tb;

   localparam int LANES = scan_pkg::NUM_LANES;
   localparam int SEL_W = $clog2(LANES);
   localparam int SIG_LEN = 4;
   localparam int REPORT_TIMEOUT = 40;
   localparam logic [31:0] SEED = 32'hea01;

   // Reference signatures with the first character in the top byte
   localparam logic [31:0] REF_SIGS [4] = '{"GET ", "EVIL", "ROOT", "XMAS"};

   logic             clk;
   logic             rst_n;
   logic             sop;
   logic [5:0]       stream_id;
   logic [7:0]       char_in;
   logic             char_in_vld;
   logic             eop;
   logic             cfg_wr;
   logic [5:0]       cfg_stream;
   logic [LANES-1:0] cfg_mask;
   logic [SEL_W-1:0] count_sel;
   logic             report_vld;
   logic [5:0]       report_stream;
   logic [LANES-1:0] report_mask;
   logic [15:0]      count_value;

   // Reference model of the matcher state per stream and lane
   int               ref_state [64][LANES];
   bit               ref_seen [64];
   logic [LANES-1:0] ref_mask [64];
   logic [15:0]      ref_count [LANES];
   logic [LANES-1:0] expected_mask;
   logic [5:0]       expected_stream;

   // Bytes of the next packet
   logic [7:0]  payload [$];
   logic [31:0] rand_state;
   int          errors;
   int          timeouts;

   always #4 clk = ~clk;

   packet_scanner_top #(
      .NUM_LANES (LANES)
   ) DUT (
      .clk           (clk),
      .rst_n         (rst_n),
      .sop           (sop),
      .stream_id     (stream_id),
      .char_in       (char_in),
      .char_in_vld   (char_in_vld),
      .eop           (eop),
      .cfg_wr        (cfg_wr),
      .cfg_stream    (cfg_stream),
      .cfg_mask      (cfg_mask),
      .count_sel     (count_sel),
      .report_vld    (report_vld),
      .report_stream (report_stream),
      .report_mask   (report_mask),
      .count_value   (count_value)
   );

   // Linear congruential generator returning the upper half of its state
   function automatic logic [31:0] random_word();
      rand_state = rand_state * 32'd1103515245 + 32'd12345;
      return rand_state >> 16;
   endfunction

   function automatic logic [7:0] sig_byte(int lane, int idx);
      logic [31:0] word;
      word = REF_SIGS[lane] >> (8 * (SIG_LEN - 1 - idx));
      return word[7:0];
   endfunction

   // A mismatch falls back to the first byte or to idle
   function automatic int next_state(int lane, int st, logic [7:0] ch);
      if (ch == sig_byte(lane, st))
         return st + 1;
      else if (ch == sig_byte(lane, 0))
         return 1;
      else
         return 0;
   endfunction

   task automatic append_text(string s);
      for (int i = 0; i < s.len(); i++)
      begin
         payload.push_back(s[i]);
      end
   endtask

   task automatic append_signature(int lane);
      for (int i = 0; i < SIG_LEN; i++)
      begin
         payload.push_back(sig_byte(lane, i));
      end
   endtask

   task automatic configure(logic [5:0] stream, logic [LANES-1:0] mask);
      @(negedge clk);
      cfg_wr     = 1'b1;
      cfg_stream = stream;
      cfg_mask   = mask;
      @(negedge clk);
      cfg_wr = 1'b0;
      ref_mask[stream] = mask;
   endtask

   // Predicts the report and the counters for the current payload
   task automatic update_model(logic [5:0] stream);
      int st;
      bit fired;
      if (!ref_seen[stream])
      begin
         for (int l = 0; l < LANES; l++)
         begin
            ref_state[stream][l] = 0;
         end
         ref_seen[stream] = 1'b1;
      end
      for (int l = 0; l < LANES; l++)
      begin
         st    = ref_state[stream][l];
         fired = 1'b0;
         for (int i = 0; i < payload.size(); i++)
         begin
            st = next_state(l, st, payload[i]);
            if (st == SIG_LEN)
            begin
               fired = 1'b1;
               st    = 0;
            end
         end
         // Disabled lane keeps its old saved state and count
         if (ref_mask[stream][l])
         begin
            ref_state[stream][l] = st;
            if (fired)
               ref_count[l] = ref_count[l] + 16'd1;
         end
         expected_mask[l] = fired & ref_mask[stream][l];
      end
      expected_stream = stream;
   endtask

   // sop then two quiet cycles, the bytes, one quiet cycle and eop
   task automatic send_packet(logic [5:0] stream);
      update_model(stream);
      @(negedge clk);
      sop       = 1'b1;
      stream_id = stream;
      @(negedge clk);
      sop = 1'b0;
      @(negedge clk);
      @(negedge clk);
      for (int i = 0; i < payload.size(); i++)
      begin
         char_in     = payload[i];
         char_in_vld = 1'b1;
         @(negedge clk);
      end
      char_in_vld = 1'b0;
      @(negedge clk);
      eop = 1'b1;
      @(negedge clk);
      eop = 1'b0;
   endtask

   task automatic expect_report();
      int waited;
      waited = 0;
      while (report_vld !== 1'b1 && waited < REPORT_TIMEOUT)
      begin
         @(negedge clk);
         waited++;
      end
      if (report_vld !== 1'b1)
      begin
         $display("Timeout at %0t: no report for stream %0d", $time, expected_stream);
         timeouts++;
      end
      else
      begin
         if (report_stream !== expected_stream)
         begin
            $display("Fail %0t: report stream %0d, expected %0d", $time, report_stream,
                     expected_stream);
            errors++;
         end
         if (report_mask !== expected_mask)
         begin
            $display("Fail %0t: report mask %b, expected %b", $time, report_mask,
                     expected_mask);
            errors++;
         end
      end
   endtask

   // Counter readback lands one cycle after count_sel
   task automatic read_count(int lane);
      @(negedge clk);
      count_sel = SEL_W'(lane);
      @(negedge clk);
      if (count_value !== ref_count[lane])
      begin
         $display("Fail %0t: lane %0d count %0d, expected %0d", $time, lane, count_value,
                  ref_count[lane]);
         errors++;
      end
   endtask

   task automatic single_packet_match();
      configure(6'd5, '1);
      payload.delete();
      append_text("xyEVILab");
      send_packet(6'd5);
      expect_report();
      read_count(1);
   endtask

   // ROOT split over two packets with another stream in between
   task automatic split_across_packets();
      configure(6'd9, '1);
      configure(6'd10, '1);
      payload.delete();
      append_text("abRO");
      send_packet(6'd9);
      expect_report();
      payload.delete();
      append_text("zzzzGE");
      send_packet(6'd10);
      expect_report();
      payload.delete();
      append_text("OTcd");
      send_packet(6'd9);
      expect_report();
      read_count(2);
   endtask

   task automatic new_stream_clean();
      configure(6'd20, '1);
      configure(6'd21, '1);
      payload.delete();
      append_text("qRO");
      send_packet(6'd20);
      expect_report();
      payload.delete();
      append_text("OTq");
      send_packet(6'd21);
      expect_report();
      read_count(2);
   endtask

   task automatic disabled_category();
      configure(6'd30, 4'b0111);
      payload.delete();
      append_text("XMAS");
      send_packet(6'd30);
      expect_report();
      read_count(3);
      // Lane back on so the same packet now counts
      configure(6'd30, '1);
      send_packet(6'd30);
      expect_report();
      read_count(3);
   endtask

   task automatic random_traffic();
      logic [31:0] r;
      logic [5:0]  stream;
      int          len;
      string       alphabet = "GETEVILROOTXMAS ";
      for (int s = 40; s < 48; s++)
      begin
         r = random_word();
         configure(6'(s), r[LANES-1:0]);
      end
      for (int p = 0; p < 24; p++)
      begin
         r      = random_word();
         stream = 6'(40 + (r % 8));
         r      = random_word();
         // Now and then the stream gets a new mask
         if (r % 4 == 0)
            configure(stream, r[4 +: LANES]);
         payload.delete();
         r   = random_word();
         len = 2 + int'(r % 10);
         for (int i = 0; i < len; i++)
         begin
            r = random_word();
            if (r % 5 == 0)
               append_signature(int'((r >> 8) % LANES));
            else
               payload.push_back(alphabet[int'(r % 16)]);
         end
         send_packet(stream);
         expect_report();
      end
      for (int l = 0; l < LANES; l++)
      begin
         read_count(l);
      end
   endtask

   initial
   begin
      clk         = 1'b0;
      rst_n       = 1'b0;
      sop         = 1'b0;
      stream_id   = '0;
      char_in     = '0;
      char_in_vld = 1'b0;
      eop         = 1'b0;
      cfg_wr      = 1'b0;
      cfg_stream  = '0;
      cfg_mask    = '0;
      count_sel   = '0;
      rand_state  = SEED;
      errors      = 0;
      timeouts    = 0;
      for (int s = 0; s < 64; s++)
      begin
         ref_seen[s] = 1'b0;
         ref_mask[s] = '0;
      end
      for (int l = 0; l < LANES; l++)
      begin
         ref_count[l] = '0;
      end
      repeat (3) @(negedge clk);
      rst_n = 1'b1;

      single_packet_match();
      split_across_packets();
      new_stream_clean();
      disabled_category();
      random_traffic();

      $display("Summary: %0d mismatches, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0)
      begin
         $display("test passed");
      end
      else
      begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// ==== files.f ====
scan_pkg.sv
stream_table.sv
pattern_dfa.sv
category_lane.sv
match_reporter.sv
packet_scanner_top.sv
packet_scanner_sva.sv
packet_scanner_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build with Verilator, run, and look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f files.f --top-module packet_scanner_tb \
   -o packet_scanner_sim \
   && ./obj_dir/packet_scanner_sim > sim.log 2>&1 \
   && grep -qx "test passed" sim.log \
   && echo "Simulation PASSED" \
   || { cat sim.log 2>/dev/null; echo "Simulation FAILED"; exit 1; }
